/* Bender.yml */
package:
  name: prf

sources:
  - include_dirs:
      - .
    files:
      - verilog/prf_pkg.sv
      - verilog/prf_rr_arbiter.sv
      - verilog/prf_ram_bank.sv
      - verilog/prf_wb_ctrl.sv
      - verilog/prf_read_ctrl.sv
      - verilog/prf.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - verif/prf_tb.sv

/* prf.f */
+incdir+.
verilog/prf_pkg.sv
verilog/prf_rr_arbiter.sv
verilog/prf_ram_bank.sv
verilog/prf_wb_ctrl.sv
verilog/prf_read_ctrl.sv
verilog/prf.sv
verif/prf_tb.sv

/* prf_config.svh */
// ----------------------------------------
// physical register file configuration
// counts and widths shared by every block
// ----------------------------------------

`ifndef PRF_CONFIG_SVH
`define PRF_CONFIG_SVH

// register storage
`define PRF_PR_COUNT 32
`define PRF_BANK_COUNT 4
`define PRF_LOG_PR_COUNT 5
`define PRF_LOG_BANK_COUNT 2
`define PRF_UPPER_PR_WIDTH 3
`define PRF_DATA_WIDTH 32

// reorder buffer index carried on completion
`define PRF_ROB_INDEX_WIDTH 5

// requesters
`define PRF_WR_COUNT 3
`define PRF_RR_COUNT 3

`endif

/* verif/prf_tb.sv */
// ----------------------------------------
// testbench for the banked register file
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "prf_config.svh"

module prf_tb;

    import prf_pkg::*;

    logic                                            CLK;
    logic                                            nRST;
    logic [`PRF_RR_COUNT-1:0]                        read_req_valid;
    pr_t [`PRF_RR_COUNT-1:0]                         read_req_pr;
    logic [`PRF_RR_COUNT-1:0]                        read_ack;
    logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] read_data;
    logic [`PRF_WR_COUNT-1:0]                        wb_valid;
    wb_req_t [`PRF_WR_COUNT-1:0]                     wb_req;
    logic [`PRF_WR_COUNT-1:0]                        wb_ready;
    wb_bus_t [`PRF_BANK_COUNT-1:0]                   wb_bus;
    logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] forward_data;
    complete_bus_t [`PRF_BANK_COUNT-1:0]             complete_bus;

    int                                                  error_count;
    int                                                  timeout_count;
    logic [31:0]                                         lfsr;
    // last requested data and the model of bank contents, by register
    logic [`PRF_DATA_WIDTH-1:0]                          req_data [`PRF_PR_COUNT];
    logic [`PRF_DATA_WIDTH-1:0]                          model [`PRF_PR_COUNT];
    logic [`PRF_BANK_COUNT-1:0]                          fwd_check;
    logic [`PRF_BANK_COUNT-1:0][`PRF_UPPER_PR_WIDTH-1:0] fwd_upper;
    logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0]     fwd_expect;
    logic [`PRF_RR_COUNT-1:0][`PRF_DATA_WIDTH-1:0]       rd_expect;
    logic [`PRF_RR_COUNT-1:0][`PRF_DATA_WIDTH-1:0]       rd_actual;
    logic [13:0]                                         idle_state;
    logic                                                in_contention;
    int                                                  order_pos;
    logic [`PRF_ROB_INDEX_WIDTH-1:0]                     order_expect;
    logic [`PRF_WR_COUNT-1:0]                            ready_expect;

    prf prf_inst (.*);

    always #10 CLK = ~CLK;

    // ----------------------------------------
    // reference model and expected values

    always_comb begin
        idle_state[13:8] = {read_ack, wb_ready};
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            idle_state[4+b] = wb_bus[b].valid;
            idle_state[b] = complete_bus[b].valid;
            fwd_expect[b] = req_data[fwd_upper[b] * `PRF_BANK_COUNT + b];
        end
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            rd_expect[r] = model[read_req_pr[r].index];
            rd_actual[r] = read_data[read_req_pr[r].split.bank];
        end
        // writer k targets register 4k+1, granted in index order
        order_expect = `PRF_ROB_INDEX_WIDTH'(4 * order_pos + 1);
        ready_expect = `PRF_WR_COUNT'((1 << (order_pos + 1)) - 1);
    end

    always @(posedge CLK) begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            // bank takes the data that forward_data must show now
            if (fwd_check[b]) begin
                model[fwd_upper[b] * `PRF_BANK_COUNT + b] <= fwd_expect[b];
            end
            fwd_check[b] <= wb_bus[b].valid;
            fwd_upper[b] <= wb_bus[b].upper;
        end
        if (!in_contention) begin
            order_pos <= 0;
        end else if (complete_bus[1].valid) begin
            order_pos <= order_pos + 1;
        end
    end

    // ----------------------------------------
    // checks

    a_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> idle_state == 14'h0700)
        else begin
            error_count++;
            $display("Error after_reset: expected %h, actual %h", 14'h0700, $sampled(idle_state));
        end

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank_chk
        a_forward: assert property (@(posedge CLK) disable iff (!nRST)
            fwd_check[b] |-> forward_data[b] == fwd_expect[b])
            else begin
                error_count++;
                $display("Error forward_data bank %0d: expected %h, actual %h", b,
                    $sampled(fwd_expect[b]), $sampled(forward_data[b]));
            end
        // reorder index equals the register number in every request
        a_complete: assert property (@(posedge CLK) disable iff (!nRST)
            wb_bus[b].valid |-> complete_bus[b] == {1'b1, wb_bus[b].upper, 2'(b)})
            else begin
                error_count++;
                $display("Error completion bank %0d: expected %h, actual %h", b,
                    {1'b1, $sampled(wb_bus[b].upper), 2'(b)}, $sampled(complete_bus[b]));
            end
        a_zero_write: assert property (@(posedge CLK) disable iff (!nRST)
            complete_bus[b].valid |-> wb_bus[b].valid == (complete_bus[b].rob_index != '0))
            else begin
                error_count++;
                $display("Error register_zero bank %0d: expected %b, actual %b", b,
                    $sampled(complete_bus[b].rob_index != '0), $sampled(wb_bus[b].valid));
            end
    end

    for (genvar r = 0; r < `PRF_RR_COUNT; r++) begin : g_read_chk
        a_read_data: assert property (@(posedge CLK) disable iff (!nRST)
            read_ack[r] |-> rd_actual[r] == rd_expect[r])
            else begin
                error_count++;
                $display("Error read_data requester %0d: expected %h, actual %h", r,
                    $sampled(rd_expect[r]), $sampled(rd_actual[r]));
            end
        for (genvar q = r + 1; q < `PRF_RR_COUNT; q++) begin : g_pair
            a_bank_port: assert property (@(posedge CLK) disable iff (!nRST)
                (read_ack[r] && read_ack[q])
                |-> read_req_pr[r].split.bank != read_req_pr[q].split.bank)
                else begin
                    error_count++;
                    $display("two reads on one bank were acked in the same cycle");
                end
        end
    end

    a_order: assert property (@(posedge CLK) disable iff (!nRST)
        (in_contention && complete_bus[1].valid)
        |-> {complete_bus[1].rob_index, wb_ready} == {order_expect, ready_expect})
        else begin
            error_count++;
            $display("Error contention_order: expected %h, actual %h",
                $sampled({order_expect, ready_expect}),
                $sampled({complete_bus[1].rob_index, wb_ready}));
        end

    a_back_to_back: assert property (@(posedge CLK) disable iff (!nRST)
        (in_contention && complete_bus[1].valid && order_pos < 2) |=> complete_bus[1].valid)
        else begin
            error_count++;
            $display("contending writes did not complete on consecutive cycles");
        end

    a_once: assert property (@(posedge CLK) disable iff (!nRST)
        (in_contention && order_pos >= 3) |-> !complete_bus[1].valid)
        else begin
            error_count++;
            $display("bank 1 completed more writes than were requested");
        end

    // ----------------------------------------
    // stimulus helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic take_random(input int bits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic note_timeout(input string what);
        timeout_count++;
        $display("Timeout: %s did not happen in time", what);
    endtask

    task automatic write_reg(input int w, input logic [4:0] pr);
        logic [31:0] data;
        int          n;
        n = 0;
        while (!wb_ready[w] && n < 20) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!wb_ready[w]) note_timeout("wb_ready");
        take_random(32, data);
        req_data[pr] = data;
        wb_req[w].data = data;
        wb_req[w].pr.index = pr;
        wb_req[w].rob_index = pr;
        wb_valid[w] = 1'b1;
        @(posedge CLK);
        #1;
        wb_valid[w] = 1'b0;
        n = 0;
        while (!(complete_bus[pr[1:0]].valid && complete_bus[pr[1:0]].rob_index == pr)
               && n < 20) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!(complete_bus[pr[1:0]].valid && complete_bus[pr[1:0]].rob_index == pr)) begin
            note_timeout("write completion");
        end
    endtask

    task automatic read_round(input logic [4:0] pr0, input logic [4:0] pr1,
                              input logic [4:0] pr2);
        logic [`PRF_RR_COUNT-1:0] seen;
        int                       n;
        read_req_pr[0].index = pr0;
        read_req_pr[1].index = pr1;
        read_req_pr[2].index = pr2;
        read_req_valid = '1;
        @(posedge CLK);
        #1;
        read_req_valid = '0;
        seen = read_ack;
        n = 0;
        while (seen != '1 && n < 20) begin
            @(posedge CLK);
            #1;
            seen |= read_ack;
            n++;
        end
        if (seen != '1) note_timeout("read acks");
        // registers stay put until the last ack has been sampled
        @(posedge CLK);
        #1;
    endtask

    // ----------------------------------------
    // test sequence

    initial begin
        logic [31:0] rnd;
        logic [4:0]  pick [3];
        int          n;
        CLK = 1'b0;
        nRST = 1'b0;
        wb_valid = '0;
        wb_req = '0;
        read_req_valid = '0;
        read_req_pr = '0;
        in_contention = 1'b0;
        error_count = 0;
        timeout_count = 0;
        lfsr = 32'd66;
        repeat (5) @(posedge CLK);
        #1 nRST = 1'b1;
        @(posedge CLK);
        #1;

        // three writers on bank 1 in the same cycle
        in_contention = 1'b1;
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            take_random(32, rnd);
            req_data[4*w+1] = rnd;
            wb_req[w].data = rnd;
            wb_req[w].pr.index = 5'(4 * w + 1);
            wb_req[w].rob_index = 5'(4 * w + 1);
        end
        wb_valid = '1;
        @(posedge CLK);
        #1;
        wb_valid = '0;
        n = 0;
        while (order_pos < 3 && n < 20) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (order_pos < 3) note_timeout("contending write completions");
        repeat (3) @(posedge CLK);
        #1 in_contention = 1'b0;

        // every register once, register 0 included
        for (int p = 0; p < `PRF_PR_COUNT; p++) begin
            write_reg(p % `PRF_WR_COUNT, 5'(p));
        end
        repeat (2) @(posedge CLK);
        #1;

        read_round(5'd1, 5'd5, 5'd2);
        read_round(5'd3, 5'd7, 5'd11);
        for (int i = 0; i < 8; i++) begin
            for (int r = 0; r < 3; r++) begin
                take_random(5, rnd);
                pick[r] = (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0];
            end
            read_round(pick[0], pick[1], pick[2]);
        end

        repeat (3) @(posedge CLK);
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/prf.sv */
// ----------------------------------------
// banked physical register file
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "prf_config.svh"

module prf (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  logic [`PRF_RR_COUNT-1:0]                            read_req_valid,
    input  prf_pkg::pr_t [`PRF_RR_COUNT-1:0]                    read_req_pr,
    output logic [`PRF_RR_COUNT-1:0]                            read_ack,
    output logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0]     read_data,
    input  logic [`PRF_WR_COUNT-1:0]                            wb_valid,
    input  prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0]                wb_req,
    output logic [`PRF_WR_COUNT-1:0]                            wb_ready,
    output prf_pkg::wb_bus_t [`PRF_BANK_COUNT-1:0]              wb_bus,
    output logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0]     forward_data,
    output prf_pkg::complete_bus_t [`PRF_BANK_COUNT-1:0]        complete_bus
);

    logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0]     ram_wdata;
    logic [`PRF_BANK_COUNT-1:0][`PRF_UPPER_PR_WIDTH-1:0] read_addr_next;

    prf_wb_ctrl wb_ctrl_inst (
        .CLK(CLK),
        .nRST(nRST),
        .wb_valid(wb_valid),
        .wb_req(wb_req),
        .wb_ready(wb_ready),
        .wb_bus(wb_bus),
        .forward_data(forward_data),
        .complete_bus(complete_bus),
        .ram_wdata(ram_wdata)
    );

    prf_read_ctrl read_ctrl_inst (
        .CLK(CLK),
        .nRST(nRST),
        .read_req_valid(read_req_valid),
        .read_req_pr(read_req_pr),
        .read_ack(read_ack),
        .read_addr_next(read_addr_next)
    );

    // writeback bus doubles as the bank write port
    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
        prf_ram_bank bank_inst (
            .CLK(CLK),
            .wen(wb_bus[b].valid),
            .waddr(wb_bus[b].upper),
            .wdata(ram_wdata[b]),
            .raddr_next(read_addr_next[b]),
            .rdata(read_data[b])
        );
    end

endmodule

`default_nettype wire

/* verilog/prf_pkg.sv */
// ----------------------------------------
// physical register file types
// register number views and bus structs
// ----------------------------------------

`default_nettype none

`include "prf_config.svh"

package prf_pkg;

    // register number split into its bank and row within the bank
    typedef struct packed {
        logic [`PRF_UPPER_PR_WIDTH-1:0] upper;
        logic [`PRF_LOG_BANK_COUNT-1:0] bank;
    } pr_split_t;

    // same register number as a flat index or as bank/row
    typedef union packed {
        logic [`PRF_LOG_PR_COUNT-1:0] index;
        pr_split_t                    split;
    } pr_t;

    // one writeback request from a requester
    typedef struct packed {
        logic [`PRF_DATA_WIDTH-1:0]      data;
        pr_t                             pr;
        logic [`PRF_ROB_INDEX_WIDTH-1:0] rob_index;
    } wb_req_t;

    // per bank writeback broadcast
    typedef struct packed {
        logic                           valid;
        logic [`PRF_UPPER_PR_WIDTH-1:0] upper;
    } wb_bus_t;

    // per bank completion broadcast
    typedef struct packed {
        logic                            valid;
        logic [`PRF_ROB_INDEX_WIDTH-1:0] rob_index;
    } complete_bus_t;

endpackage

`default_nettype wire

/* verilog/prf_ram_bank.sv */
// ----------------------------------------
// one register file bank
// distributed RAM, 1 write and 1 read port
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "prf_config.svh"

module prf_ram_bank (
    input  logic                           CLK,
    input  logic                           wen,
    input  logic [`PRF_UPPER_PR_WIDTH-1:0] waddr,
    input  logic [`PRF_DATA_WIDTH-1:0]     wdata,
    input  logic [`PRF_UPPER_PR_WIDTH-1:0] raddr_next,
    output logic [`PRF_DATA_WIDTH-1:0]     rdata
);

    localparam int DEPTH = `PRF_PR_COUNT / `PRF_BANK_COUNT;

    logic [`PRF_DATA_WIDTH-1:0]     mem [DEPTH];
    logic [`PRF_UPPER_PR_WIDTH-1:0] raddr;

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
        // read index captured with the grant
        raddr <= raddr_next;
    end

    // async read sees a write made at the same edge as the index
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* verilog/prf_read_ctrl.sv */
// ----------------------------------------
// read control
// hold, per-bank arbitration, read indexes
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "prf_config.svh"

module prf_read_ctrl (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  logic [`PRF_RR_COUNT-1:0]                            read_req_valid,
    input  prf_pkg::pr_t [`PRF_RR_COUNT-1:0]                    read_req_pr,
    output logic [`PRF_RR_COUNT-1:0]                            read_ack,
    output logic [`PRF_BANK_COUNT-1:0][`PRF_UPPER_PR_WIDTH-1:0] read_addr_next
);

    import prf_pkg::*;

    logic [`PRF_RR_COUNT-1:0]                        held_valid;
    logic [`PRF_RR_COUNT-1:0]                        next_held_valid;
    pr_t [`PRF_RR_COUNT-1:0]                         held_pr;
    logic [`PRF_RR_COUNT-1:0]                        cmp_valid;
    pr_t [`PRF_RR_COUNT-1:0]                         cmp_pr;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0]   req_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0]   grant_by_bank;
    logic [`PRF_RR_COUNT-1:0]                        next_ack;

    // requester may not issue again while its read is held
    assign cmp_valid = read_req_valid | held_valid;

    always_comb begin
        req_by_bank = '0;
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            cmp_pr[r] = held_valid[r] ? held_pr[r] : read_req_pr[r];
            req_by_bank[cmp_pr[r].split.bank][r] = cmp_valid[r];
        end
    end

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_arb
        prf_rr_arbiter #(
            .WIDTH(`PRF_RR_COUNT)
        ) arb_inst (
            .CLK(CLK),
            .nRST(nRST),
            .req(req_by_bank[b]),
            .grant(grant_by_bank[b])
        );
    end

    // winning row goes straight to the bank index register
    always_comb begin
        next_ack = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            next_ack |= grant_by_bank[b];
            read_addr_next[b] = '0;
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                read_addr_next[b] |= cmp_pr[r].split.upper
                    & {`PRF_UPPER_PR_WIDTH{grant_by_bank[b][r]}};
            end
        end
        next_held_valid = cmp_valid & ~next_ack;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            read_ack <= '0;
        end else begin
            held_valid <= next_held_valid;
            read_ack <= next_ack;
        end
    end

    always_ff @(posedge CLK) begin
        held_pr <= cmp_pr;
    end

    // every ack answers a request live or held one cycle earlier
    for (genvar r = 0; r < `PRF_RR_COUNT; r++) begin : g_chk
        a_ack_has_req: assert property (@(posedge CLK) disable iff (!nRST)
            read_ack[r] |-> $past(read_req_valid[r] || held_valid[r]));
    end

endmodule

`default_nettype wire

/* verilog/prf_rr_arbiter.sv */
// ----------------------------------------
// rotating arbiter for one bank
// lowest index above the last grant wins
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module prf_rr_arbiter #(
    parameter int WIDTH = 3
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] grant
);

    // indices strictly above the last granted requester
    logic [WIDTH-1:0] mask;
    logic [WIDTH-1:0] next_mask;
    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] masked_grant;
    logic [WIDTH-1:0] unmasked_grant;

    function automatic logic [WIDTH-1:0] pick_lowest(input logic [WIDTH-1:0] vec);
        logic [WIDTH-1:0] one_hot;
        logic             found;
        one_hot = '0;
        found = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (vec[i] && !found) begin
                one_hot[i] = 1'b1;
                found = 1'b1;
            end
        end
        return one_hot;
    endfunction

    assign masked_req = req & mask;

    always_comb begin
        masked_grant = pick_lowest(masked_req);
        unmasked_grant = pick_lowest(req);
        // wrap around to the bottom when nothing is left above
        grant = (|masked_req) ? masked_grant : unmasked_grant;

        next_mask = '0;
        for (int i = 1; i < WIDTH; i++) begin
            next_mask[i] = next_mask[i-1] | grant[i-1];
        end
    end

    // mask only moves on a grant, so an idle bank keeps its position
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mask <= '0;
        end else if (|grant) begin
            mask <= next_mask;
        end
    end

    a_grant_legal: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(grant) && ((grant & ~req) == '0));

endmodule

`default_nettype wire

/* verilog/prf_wb_ctrl.sv */
// ----------------------------------------
// writeback control
// hold, per-bank arbitration, bus registers
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "prf_config.svh"

module prf_wb_ctrl (
    input  logic                                             CLK,
    input  logic                                             nRST,
    input  logic [`PRF_WR_COUNT-1:0]                         wb_valid,
    input  prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0]             wb_req,
    output logic [`PRF_WR_COUNT-1:0]                         wb_ready,
    output prf_pkg::wb_bus_t [`PRF_BANK_COUNT-1:0]           wb_bus,
    output logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0]  forward_data,
    output prf_pkg::complete_bus_t [`PRF_BANK_COUNT-1:0]     complete_bus,
    output logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0]  ram_wdata
);

    import prf_pkg::*;

    // ----------------------------------------
    // request hold and bank demux

    logic [`PRF_WR_COUNT-1:0]                        held_valid;
    logic [`PRF_WR_COUNT-1:0]                        next_held_valid;
    wb_req_t [`PRF_WR_COUNT-1:0]                     held_req;
    logic [`PRF_WR_COUNT-1:0]                        cmp_valid;
    wb_req_t [`PRF_WR_COUNT-1:0]                     cmp_req;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0]   req_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0]   grant_by_bank;
    logic [`PRF_WR_COUNT-1:0]                        grant_by_wr;

    // a requester with a held request is not listened to
    assign cmp_valid = held_valid | (wb_valid & ~held_valid);
    assign wb_ready = ~held_valid;

    always_comb begin
        req_by_bank = '0;
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            cmp_req[w] = held_valid[w] ? held_req[w] : wb_req[w];
            req_by_bank[cmp_req[w].pr.split.bank][w] = cmp_valid[w];
        end
    end

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_arb
        prf_rr_arbiter #(
            .WIDTH(`PRF_WR_COUNT)
        ) arb_inst (
            .CLK(CLK),
            .nRST(nRST),
            .req(req_by_bank[b]),
            .grant(grant_by_bank[b])
        );
    end

    // ----------------------------------------
    // one-hot select of the winner per bank

    pr_t [`PRF_BANK_COUNT-1:0]                       sel_pr;
    wb_bus_t [`PRF_BANK_COUNT-1:0]                   next_wb_bus;
    complete_bus_t [`PRF_BANK_COUNT-1:0]             next_complete_bus;
    logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] next_wdata;

    always_comb begin
        grant_by_wr = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            grant_by_wr |= grant_by_bank[b];
            sel_pr[b] = '0;
            next_wdata[b] = '0;
            next_complete_bus[b].rob_index = '0;
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                sel_pr[b].index |= cmp_req[w].pr.index
                    & {`PRF_LOG_PR_COUNT{grant_by_bank[b][w]}};
                next_wdata[b] |= cmp_req[w].data & {`PRF_DATA_WIDTH{grant_by_bank[b][w]}};
                next_complete_bus[b].rob_index |= cmp_req[w].rob_index
                    & {`PRF_ROB_INDEX_WIDTH{grant_by_bank[b][w]}};
            end
            // register 0 completes but is never written or broadcast
            next_wb_bus[b].valid = (|grant_by_bank[b]) && (sel_pr[b].index != '0);
            next_wb_bus[b].upper = sel_pr[b].split.upper;
            next_complete_bus[b].valid = |grant_by_bank[b];
        end
        next_held_valid = cmp_valid & ~grant_by_wr;
    end

    // ----------------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            wb_bus <= '0;
            complete_bus <= '0;
        end else begin
            held_valid <= next_held_valid;
            wb_bus <= next_wb_bus;
            complete_bus <= next_complete_bus;
        end
    end

    // forward data trails the bank write by one cycle
    always_ff @(posedge CLK) begin
        held_req <= cmp_req;
        ram_wdata <= next_wdata;
        forward_data <= ram_wdata;
    end

    // a grant while ready is high must be the live request
    for (genvar w = 0; w < `PRF_WR_COUNT; w++) begin : g_chk
        a_ready_grant: assert property (@(posedge CLK) disable iff (!nRST)
            (grant_by_wr[w] && wb_ready[w]) |-> (wb_valid[w] && !held_valid[w]));
    end

endmodule

`default_nettype wire
